//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_ex_pipe
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- alu.sv
`timescale 1ns/1ps

module alu
    import ex_pkg::*;
(
    input  alu_op_e         alu_op_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    output logic [XLEN-1:0] res_o
);

    logic [4:0]        shamt;
    logic [2*XLEN-1:0] mul_a;
    logic [2*XLEN-1:0] mul_b;
    logic [2*XLEN-1:0] mul_p;
    logic              div_zero;
    logic              div_ovf;
    logic [XLEN-1:0]   quot_s;
    logic [XLEN-1:0]   rem_s;
    logic [XLEN-1:0]   quot_u;
    logic [XLEN-1:0]   rem_u;

    // only the low five bits shift
    assign shamt = src2_i[4:0];

    // one 64-bit multiplier, operands sign or zero extended per op
    always_comb begin
        mul_a = {{XLEN{1'b0}}, src1_i};
        mul_b = {{XLEN{1'b0}}, src2_i};
        if (alu_op_i == alu_mulh || alu_op_i == alu_mulhsu) begin
            mul_a[2*XLEN-1:XLEN] = {XLEN{src1_i[XLEN-1]}};
        end
        // mulhsu keeps src2 unsigned
        if (alu_op_i == alu_mulh) begin
            mul_b[2*XLEN-1:XLEN] = {XLEN{src2_i[XLEN-1]}};
        end
    end

    // low 64 bits of the product are exact for every signedness mix
    assign mul_p = mul_a * mul_b;

    assign div_zero = (src2_i == '0);
    // most negative over minus one
    assign div_ovf  = (src1_i == {1'b1, {(XLEN-1){1'b0}}}) && (src2_i == '1);

    always_comb begin
        // divide by zero defaults: all ones quotient, dividend remainder
        quot_u = '1;
        rem_u  = src1_i;
        quot_s = '1;
        rem_s  = src1_i;
        if (!div_zero) begin
            quot_u = src1_i / src2_i;
            rem_u  = src1_i % src2_i;
            if (div_ovf) begin
                quot_s = src1_i;
                rem_s  = '0;
            end else begin
                quot_s = $signed(src1_i) / $signed(src2_i);
                rem_s  = $signed(src1_i) % $signed(src2_i);
            end
        end
    end

    always_comb begin
        case (alu_op_i)
            alu_add:      res_o = src1_i + src2_i;
            alu_sub:      res_o = src1_i - src2_i;
            alu_sll:      res_o = src1_i << shamt;
            alu_slt:      res_o = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
            alu_sltu:     res_o = {{(XLEN-1){1'b0}}, src1_i < src2_i};
            alu_xor:      res_o = src1_i ^ src2_i;
            alu_srl:      res_o = src1_i >> shamt;
            alu_sra:      res_o = $signed(src1_i) >>> shamt;
            alu_or:       res_o = src1_i | src2_i;
            alu_and:      res_o = src1_i & src2_i;
            // upper immediate arrives already shifted on src2
            alu_lui_pass: res_o = src2_i;
            alu_mul:      res_o = mul_p[XLEN-1:0];
            alu_mulh,
            alu_mulhsu,
            alu_mulhu:    res_o = mul_p[2*XLEN-1:XLEN];
            alu_div:      res_o = quot_s;
            alu_divu:     res_o = quot_u;
            alu_rem:      res_o = rem_s;
            alu_remu:     res_o = rem_u;
            default:      res_o = '0;
        endcase
    end

endmodule

//--- bcu.sv
`timescale 1ns/1ps

module bcu
    import ex_pkg::*;
(
    input  br_kind_e        br_kind_i,
    input  logic [2:0]      funct3_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    output redir_t          redir_o
);

    logic            cond;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] pc_seq;
    logic [XLEN-1:0] jalr_sum;

    assign pc_imm   = pc_i + imm_i;
    assign pc_seq   = pc_i + XLEN'(4);
    assign jalr_sum = rs1_i + imm_i;

    // branch condition by funct3
    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond = (rs1_i == rs2_i);
            F3_BNE:  cond = (rs1_i != rs2_i);
            F3_BLT:  cond = ($signed(rs1_i) < $signed(rs2_i));
            F3_BGE:  cond = ($signed(rs1_i) >= $signed(rs2_i));
            F3_BLTU: cond = (rs1_i < rs2_i);
            F3_BGEU: cond = (rs1_i >= rs2_i);
            // reserved encodings never branch
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        redir_o.taken  = 1'b0;
        redir_o.target = pc_seq;
        case (br_kind_i)
            br_branch: begin
                redir_o.taken = cond;
                if (cond) begin
                    redir_o.target = pc_imm;
                end
            end
            br_jal: begin
                redir_o.taken  = 1'b1;
                redir_o.target = pc_imm;
            end
            // jalr target has bit 0 cleared
            br_jalr: begin
                redir_o.taken  = 1'b1;
                redir_o.target = {jalr_sum[XLEN-1:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

//--- ex_pipe_regs.sv
`timescale 1ns/1ps

module ex_pipe_regs
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  ex_req_t         req_i,
    input  logic [XLEN-1:0] alu_res_i,
    input  redir_t          redir_i,
    output ex_req_t         id_ex_o,
    output res_t            ex_tag_o,
    output res_t            ls_tag_o,
    output res_t            wb_o,
    output redir_t          redir_o
);

    ex_req_t id_ex_q;
    res_t    ex_nxt;
    res_t    ex_q;
    res_t    ls_q;
    res_t    wb_q;
    res_t    ret_q;
    redir_t  redir_nxt;
    redir_t  redir_q;

    // register read that missed a commit in the same cycle
    function automatic logic [XLEN-1:0] late_rd(logic [REG_AW-1:0] idx,
                                                logic [XLEN-1:0] val,
                                                res_t late);
        if (idx == '0) begin
            return '0;
        end
        if (late.valid && late.rd_we && (late.rd_idx == idx)) begin
            return late.data;
        end
        return val;
    endfunction

    // ex slot built from the instruction now in execute
    always_comb begin
        ex_nxt.valid  = id_ex_q.valid;
        ex_nxt.rd_we  = id_ex_q.rd_we;
        ex_nxt.rd_idx = id_ex_q.rd_idx;
        ex_nxt.data   = alu_res_i;
    end

    // bubbles never redirect
    assign redir_nxt.taken  = id_ex_q.valid && redir_i.taken;
    assign redir_nxt.target = redir_i.target;

    always_ff @(posedge clk) begin
        id_ex_q <= req_i;
        ex_q    <= ex_nxt;
        ls_q    <= ex_q;
        wb_q    <= ls_q;
        ret_q   <= wb_q;
        redir_q <= redir_nxt;
        // only the valid bits and taken need clearing
        if (rst_i) begin
            id_ex_q.valid <= 1'b0;
            ex_q.valid    <= 1'b0;
            ls_q.valid    <= 1'b0;
            wb_q.valid    <= 1'b0;
            ret_q.valid   <= 1'b0;
            redir_q.taken <= 1'b0;
        end
    end

    // ret holds the commit that was on wb_o when this request read regs
    always_comb begin
        id_ex_o         = id_ex_q;
        id_ex_o.rs1_val = late_rd(id_ex_q.rs1_idx, id_ex_q.rs1_val, ret_q);
        id_ex_o.rs2_val = late_rd(id_ex_q.rs2_idx, id_ex_q.rs2_val, ret_q);
    end

    assign ex_tag_o = ex_q;
    assign ls_tag_o = ls_q;
    assign wb_o     = wb_q;
    assign redir_o  = redir_q;

endmodule

//--- ex_pipe_top.sv
`timescale 1ns/1ps

module ex_pipe_top
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  ex_req_t req_i,
    output res_t    wb_o,
    output redir_t  redir_o
);

    ex_req_t         id_ex;
    res_t            ex_tag;
    res_t            ls_tag;
    res_t            wb_tag;
    fw_sel_e         rs1_sel;
    fw_sel_e         rs2_sel;
    logic [XLEN-1:0] alu_res;
    redir_t          redir;

    // id_ex plus the ex, ls, wb and ret result slots
    ex_pipe_regs u_regs (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .alu_res_i (alu_res),
        .redir_i   (redir),
        .id_ex_o   (id_ex),
        .ex_tag_o  (ex_tag),
        .ls_tag_o  (ls_tag),
        .wb_o      (wb_tag),
        .redir_o   (redir_o)
    );

    assign wb_o = wb_tag;

    // one, two and three instructions older
    fwd_unit u_fwd (
        .rs1_idx_i (id_ex.rs1_idx),
        .rs2_idx_i (id_ex.rs2_idx),
        .ex_tag_i  (ex_tag),
        .ls_tag_i  (ls_tag),
        .wb_tag_i  (wb_tag),
        .rs1_sel_o (rs1_sel),
        .rs2_sel_o (rs2_sel)
    );

    // no memory stage here, store datum left open
    ex_stage u_ex (
        .req_i     (id_ex),
        .rs1_sel_i (rs1_sel),
        .rs2_sel_i (rs2_sel),
        .ex_fw_i   (ex_tag.data),
        .ls_fw_i   (ls_tag.data),
        .wb_fw_i   (wb_tag.data),
        .alu_res_o (alu_res),
        .rs2_o     (),
        .redir_o   (redir)
    );

endmodule

//--- ex_pkg.sv
package ex_pkg;

    // datapath width and register index width
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // branch funct3 encodings
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu operations, base set then M extension
    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_lui_pass,
        alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
        alu_div, alu_divu, alu_rem, alu_remu
    } alu_op_e;

    typedef enum logic {
        src1_rs1,
        src1_pc
    } src1_sel_e;

    // bit 1 picks the constant, bit 0 the immediate
    typedef enum logic [1:0] {
        src2_rs2  = 2'b00,
        src2_imm  = 2'b01,
        src2_four = 2'b10
    } src2_sel_e;

    // operand source for forwarding
    typedef enum logic [1:0] {
        fw_rf = 2'd0,
        fw_ex = 2'd1,
        fw_ls = 2'd2,
        fw_wb = 2'd3
    } fw_sel_e;

    typedef enum logic [1:0] {
        br_none,
        br_branch,
        br_jal,
        br_jalr
    } br_kind_e;

    // decoded instruction entering execute
    // rs values are the register file as read while the request is presented
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [2:0]        funct3;
        alu_op_e           alu_op;
        src1_sel_e         src1_sel;
        src2_sel_e         src2_sel;
        br_kind_e          br_kind;
        logic [REG_AW-1:0] rs1_idx;
        logic [REG_AW-1:0] rs2_idx;
        logic [REG_AW-1:0] rd_idx;
        logic              rd_we;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
        logic [XLEN-1:0]   imm;
    } ex_req_t;

    // one result slot in the back half of the pipe
    typedef struct packed {
        logic              valid;
        logic              rd_we;
        logic [REG_AW-1:0] rd_idx;
        logic [XLEN-1:0]   data;
    } res_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redir_t;

endpackage

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  ex_req_t         req_i,
    input  fw_sel_e         rs1_sel_i,
    input  fw_sel_e         rs2_sel_i,
    input  logic [XLEN-1:0] ex_fw_i,
    input  logic [XLEN-1:0] ls_fw_i,
    input  logic [XLEN-1:0] wb_fw_i,
    output logic [XLEN-1:0] alu_res_o,
    output logic [XLEN-1:0] rs2_o,
    output redir_t          redir_o
);

    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;

    // four-way operand mux
    function automatic logic [XLEN-1:0] fwd_mux(fw_sel_e sel,
                                                logic [XLEN-1:0] rf_val,
                                                logic [XLEN-1:0] ex_val,
                                                logic [XLEN-1:0] ls_val,
                                                logic [XLEN-1:0] wb_val);
        case (sel)
            fw_ex:   return ex_val;
            fw_ls:   return ls_val;
            fw_wb:   return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign rs1 = fwd_mux(rs1_sel_i, req_i.rs1_val, ex_fw_i, ls_fw_i, wb_fw_i);
    assign rs2 = fwd_mux(rs2_sel_i, req_i.rs2_val, ex_fw_i, ls_fw_i, wb_fw_i);

    // forwarded store datum
    assign rs2_o = rs2;

    assign src1 = (req_i.src1_sel == src1_pc) ? req_i.pc : rs1;

    // constant 4 gives the link value for jal and jalr
    always_comb begin
        case (req_i.src2_sel)
            src2_imm:  src2 = req_i.imm;
            src2_four: src2 = XLEN'(4);
            default:   src2 = rs2;
        endcase
    end

    alu u_alu (
        .alu_op_i (req_i.alu_op),
        .src1_i   (src1),
        .src2_i   (src2),
        .res_o    (alu_res_o)
    );

    // compare on forwarded operands, not the raw register values
    bcu u_bcu (
        .br_kind_i (req_i.br_kind),
        .funct3_i  (req_i.funct3),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .imm_i     (req_i.imm),
        .pc_i      (req_i.pc),
        .redir_o   (redir_o)
    );

endmodule

//--- filelist.f
ex_pkg.sv
alu.sv
bcu.sv
fwd_unit.sv
ex_stage.sv
ex_pipe_regs.sv
ex_pipe_top.sv
tb_ex_pipe.sv

//--- fwd_unit.sv
`timescale 1ns/1ps

module fwd_unit
    import ex_pkg::*;
(
    input  logic [REG_AW-1:0] rs1_idx_i,
    input  logic [REG_AW-1:0] rs2_idx_i,
    input  res_t              ex_tag_i,
    input  res_t              ls_tag_i,
    input  res_t              wb_tag_i,
    output fw_sel_e           rs1_sel_o,
    output fw_sel_e           rs2_sel_o
);

    // slot holds a live write to this register
    function automatic logic slot_hit(res_t tag, logic [REG_AW-1:0] idx);
        return tag.valid && tag.rd_we && (tag.rd_idx != '0) && (tag.rd_idx == idx);
    endfunction

    // youngest slot wins
    function automatic fw_sel_e pick_src(logic [REG_AW-1:0] idx,
                                         res_t ex_tag,
                                         res_t ls_tag,
                                         res_t wb_tag);
        fw_sel_e sel;
        sel = fw_rf;
        if (slot_hit(ex_tag, idx)) begin
            sel = fw_ex;
        end else if (slot_hit(ls_tag, idx)) begin
            sel = fw_ls;
        end else if (slot_hit(wb_tag, idx)) begin
            sel = fw_wb;
        end
        return sel;
    endfunction

    // x0 never matches since slot_hit rejects rd 0
    assign rs1_sel_o = pick_src(rs1_idx_i, ex_tag_i, ls_tag_i, wb_tag_i);
    assign rs2_sel_o = pick_src(rs2_idx_i, ex_tag_i, ls_tag_i, wb_tag_i);

endmodule

//--- tb_ex_pipe.sv
`timescale 1ns/1ps

module tb_ex_pipe
    import ex_pkg::*;
();

    // upper bound on stimulus cycles, sets the watchdog
    localparam int NUM_CYCLES = 750;

    typedef struct {
        logic              rd_we;
        logic [REG_AW-1:0] rd_idx;
        logic [XLEN-1:0]   data;
        int                due;
        string             name;
    } exp_res_t;

    typedef struct {
        logic            taken;
        logic [XLEN-1:0] target;
        int              due;
        string           name;
    } exp_redir_t;

    logic    clk;
    logic    rst_i;
    ex_req_t req_i;
    res_t    wb_o;
    redir_t  redir_o;

    // crf follows commits on wb_o, arf follows issue order
    logic [XLEN-1:0] crf [32];
    logic [XLEN-1:0] arf [32];
    exp_res_t        res_q[$];
    exp_redir_t      redir_q[$];
    logic [31:0]     lcg_state;
    int              cyc;
    int              errors;
    int              checks;
    string           test_name;

    ex_pipe_top dut_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (req_i),
        .wb_o    (wb_o),
        .redir_o (redir_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #((NUM_CYCLES + 20 + 10) * 8);
        $display("watchdog expired before the stimulus finished");
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'((lcg_next() >> 8) % n);
    endfunction

    // architectural result of one operation
    function automatic logic [31:0] ref_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic signed [63:0] ps;
        logic [63:0]        pu;
        case (op)
            alu_add:      return a + b;
            alu_sub:      return a - b;
            alu_sll:      return a << b[4:0];
            alu_slt:      return {31'b0, $signed(a) < $signed(b)};
            alu_sltu:     return {31'b0, a < b};
            alu_xor:      return a ^ b;
            alu_srl:      return a >> b[4:0];
            alu_sra:      return 32'($signed(a) >>> b[4:0]);
            alu_or:       return a | b;
            alu_and:      return a & b;
            alu_lui_pass: return b;
            alu_mul:      return a * b;
            alu_mulh: begin
                ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                return ps[63:32];
            end
            alu_mulhsu: begin
                pu = {{32{a[31]}}, a} * {32'b0, b};
                return pu[63:32];
            end
            alu_mulhu: begin
                pu = {32'b0, a} * {32'b0, b};
                return pu[63:32];
            end
            alu_div: begin
                if (b == 0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return 32'($signed(a) / $signed(b));
            end
            alu_divu:     return (b == 0) ? 32'hffff_ffff : a / b;
            alu_rem: begin
                if (b == 0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                return 32'($signed(a) % $signed(b));
            end
            alu_remu:     return (b == 0) ? a : a % b;
            default:      return 32'h0;
        endcase
    endfunction

    // compare outputs sampled before this edge against the queues
    task automatic check_outputs();
        exp_res_t   e;
        exp_redir_t d;
        if (redir_q.size() > 0 && redir_q[0].due == cyc) begin
            d = redir_q.pop_front();
            checks++;
            assert (redir_o.taken == d.taken && redir_o.target == d.target)
            else begin
                errors++;
                $display("CHECK FAILED %s redirect expected %b/%h actual %b/%h",
                         d.name, d.taken, d.target, redir_o.taken, redir_o.target);
            end
        end else begin
            assert (!redir_o.taken) else begin
                errors++;
                $display("redirect taken in cycle %0d with none expected", cyc);
            end
        end
        if (wb_o.valid) begin
            if (res_q.size() == 0) begin
                errors++;
                $display("wb_o valid in cycle %0d with no result pending", cyc);
            end else begin
                e = res_q.pop_front();
                checks++;
                assert (e.due == cyc) else begin
                    errors++;
                    $display("CHECK FAILED %s latency expected %0d actual %0d",
                             e.name, e.due, cyc);
                end
                assert (wb_o.rd_we == e.rd_we && wb_o.rd_idx == e.rd_idx && wb_o.data == e.data)
                else begin
                    errors++;
                    $display("CHECK FAILED %s wb expected x%0d=%h actual x%0d=%h",
                             e.name, e.rd_idx, e.data, wb_o.rd_idx, wb_o.data);
                end
                if (e.rd_we && e.rd_idx != 0) crf[e.rd_idx] = e.data;
            end
        end else if (res_q.size() > 0 && res_q[0].due == cyc) begin
            errors++;
            $display("wb_o missing a result for %s in cycle %0d", res_q[0].name, cyc);
        end
    endtask

    // one clock: check, then present the next request
    task automatic tick(input ex_req_t r);
        exp_res_t    e;
        exp_redir_t  d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s1;
        logic [31:0] s2;
        logic        cond;
        @(posedge clk);
        check_outputs();
        cyc++;
        if (r.valid) begin
            r.rs1_val = crf[r.rs1_idx];
            r.rs2_val = crf[r.rs2_idx];
            a  = arf[r.rs1_idx];
            b  = arf[r.rs2_idx];
            s1 = (r.src1_sel == src1_pc) ? r.pc : a;
            s2 = (r.src2_sel == src2_imm) ? r.imm : (r.src2_sel == src2_four) ? 32'd4 : b;
            e.rd_we  = r.rd_we;
            e.rd_idx = r.rd_idx;
            e.data   = ref_alu(r.alu_op, s1, s2);
            e.due    = cyc + 4;
            e.name   = test_name;
            res_q.push_back(e);
            if (r.rd_we && r.rd_idx != 0) arf[r.rd_idx] = e.data;
            case (r.funct3)
                F3_BEQ:  cond = (a == b);
                F3_BNE:  cond = (a != b);
                F3_BLT:  cond = ($signed(a) < $signed(b));
                F3_BGE:  cond = ($signed(a) >= $signed(b));
                F3_BLTU: cond = (a < b);
                F3_BGEU: cond = (a >= b);
                default: cond = 1'b0;
            endcase
            d.taken  = (r.br_kind == br_jal) || (r.br_kind == br_jalr) ||
                       (r.br_kind == br_branch && cond);
            // fall through to the next sequential pc when not taken
            if (!d.taken) begin
                d.target = r.pc + 32'd4;
            end else if (r.br_kind == br_jalr) begin
                d.target = (a + r.imm) & ~32'd1;
            end else begin
                d.target = r.pc + r.imm;
            end
            d.due    = cyc + 2;
            d.name   = test_name;
            redir_q.push_back(d);
        end
        req_i <= r;
    endtask

    task automatic idle(int n);
        repeat (n) tick('0);
    endtask

    function automatic ex_req_t make_alu(alu_op_e op, int rd, int rs1, int rs2, logic use_imm);
        ex_req_t     r;
        logic [31:0] pc_raw;
        pc_raw     = lcg_next();
        r          = '0;
        r.valid    = 1'b1;
        r.pc       = {pc_raw[31:2], 2'b00};
        r.alu_op   = op;
        r.src1_sel = src1_rs1;
        r.src2_sel = use_imm ? src2_imm : src2_rs2;
        r.br_kind  = br_none;
        r.rd_idx   = 5'(rd);
        r.rs1_idx  = 5'(rs1);
        r.rs2_idx  = 5'(rs2);
        r.rd_we    = 1'b1;
        r.imm      = lcg_next();
        return r;
    endfunction

    function automatic ex_req_t make_br(br_kind_e kind, logic [2:0] f3, int rd, int rs1, int rs2);
        ex_req_t     r;
        logic [31:0] x;
        x          = lcg_next();
        r          = make_alu(alu_add, rd, rs1, rs2, 1'b0);
        r.br_kind  = kind;
        r.funct3   = f3;
        r.imm      = {{20{x[11]}}, x[11:1], 1'b0};
        // link value pc+4 on jumps
        if (kind != br_branch) begin
            r.src1_sel = src1_pc;
            r.src2_sel = src2_four;
        end else begin
            r.rd_we = 1'b0;
        end
        return r;
    endfunction

    task automatic set_reg(int rd, logic [31:0] val);
        ex_req_t r;
        r     = make_alu(alu_lui_pass, rd, 0, 0, 1'b1);
        r.imm = val;
        tick(r);
    endtask

    task automatic random_op(int max_reg);
        int sel;
        sel = rand_below(10);
        if (sel < 4) begin
            tick(make_alu(alu_op_e'(rand_below(11)), rand_below(max_reg),
                          rand_below(max_reg), rand_below(max_reg), rand_below(2) == 0));
        end else if (sel < 6) begin
            tick(make_alu(alu_op_e'(11 + rand_below(8)), rand_below(max_reg),
                          rand_below(max_reg), rand_below(max_reg), 1'b0));
        end else if (sel < 8) begin
            tick(make_br(br_branch, 3'(rand_below(8)), 0, rand_below(max_reg),
                         rand_below(max_reg)));
        end else if (sel < 9) begin
            tick(make_br(br_jal, 3'b0, rand_below(max_reg), 0, 0));
        end else begin
            tick(make_br(br_jalr, 3'b0, rand_below(max_reg), rand_below(max_reg), 0));
        end
    endtask

    initial begin
        logic [2:0] f3_list [6];
        f3_list   = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        lcg_state = 32'd25627;
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            crf[i] = '0;
            arf[i] = '0;
        end
        rst_i = 1'b1;
        req_i = '0;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;

        test_name = "reset_idle";
        idle(20);

        test_name = "alu_independent";
        for (int i = 1; i < 8; i++) set_reg(i, lcg_next());
        repeat (40) begin
            tick(make_alu(alu_op_e'(rand_below(11)), 1 + rand_below(7),
                          1 + rand_below(7), 1 + rand_below(7), rand_below(3) == 0));
            idle(3);
        end

        // reader follows the writer at distance d
        test_name = "forwarding";
        for (int d = 1; d <= 3; d++) begin
            repeat (4) begin
                set_reg(5, lcg_next());
                repeat (d - 1) set_reg(6, lcg_next());
                tick(make_alu(alu_xor, 8, 5, 6, 1'b0));
            end
        end
        set_reg(0, lcg_next());
        tick(make_alu(alu_or, 9, 0, 0, 1'b0));
        repeat (20) tick(make_alu(alu_op_e'(rand_below(11)), 1 + rand_below(3),
                                  1 + rand_below(3), 1 + rand_below(3), 1'b0));

        test_name = "muldiv";
        set_reg(6, 32'h8000_0000);
        set_reg(7, 32'hffff_ffff);
        for (int op = 11; op < 19; op++) begin
            tick(make_alu(alu_op_e'(op), 10, 6, 7, 1'b0));
            tick(make_alu(alu_op_e'(op), 11, 6, 0, 1'b0));
        end
        repeat (40) tick(make_alu(alu_op_e'(11 + rand_below(8)), 1 + rand_below(7),
                                  1 + rand_below(7), 1 + rand_below(7), 1'b0));

        test_name = "branch";
        for (int i = 0; i < 6; i++) begin
            repeat (6) begin
                tick(make_br(br_branch, f3_list[i], 0, 1 + rand_below(3), 1 + rand_below(3)));
            end
            set_reg(1 + rand_below(3), lcg_next());
        end
        repeat (4) tick(make_br(br_jal, 3'b0, 5, 0, 0));
        repeat (4) tick(make_br(br_jalr, 3'b0, 1 + rand_below(7), 1 + rand_below(7), 0));

        test_name = "mixed_stream";
        repeat (300) random_op(8);
        idle(12);

        if (res_q.size() != 0 || redir_q.size() != 0) begin
            errors++;
            $display("%0d results and %0d redirects never appeared",
                     res_q.size(), redir_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
